//--- common/hist_ctrl_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// controller types: frame state, pixel input and status word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "hist_defines.svh"

package hist_ctrl_pkg;

    typedef enum logic [2:0] {
        st_idle    = 3'd0,
        st_clear   = 3'd1, // RAM is sweeping every bin to zero
        st_collect = 3'd2,
        st_drain   = 3'd3, // accumulator pipeline empties
        st_done    = 3'd4  // host may read the bins back
    } hist_state_e;

    typedef struct packed {
        logic                       valid;
        logic [`HIST_BIN_WIDTH-1:0] bin;
    } pixel_t;

    typedef struct packed {
        hist_state_e state;
        logic        ready;
    } hist_status_t;

endpackage

`default_nettype wire

//--- common/hist_defines.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// width macros for the histogram engine: bin index, bin count
// and the address width of one RAM bank
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef HIST_DEFINES_SVH
`define HIST_DEFINES_SVH

// 256 bins
`define HIST_BIN_WIDTH 8

// counts saturate at 255
`define HIST_COUNT_WIDTH 8

// 64 words per bank, so four banks cover all bins
`define HIST_UNIT_ADDR_WIDTH 6

`endif

//--- common/hist_ram_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RAM port types: count word, read port and write port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "hist_defines.svh"

package hist_ram_pkg;

    typedef logic [`HIST_COUNT_WIDTH-1:0] count_t;

    typedef struct packed {
        logic                       we;
        logic [`HIST_BIN_WIDTH-1:0] addr;
        count_t                     data;
    } ram_wr_t;

    typedef struct packed {
        logic                       en;
        logic [`HIST_BIN_WIDTH-1:0] addr;
    } ram_rd_t;

endpackage

`default_nettype wire

//--- hist_ram/clear_sweep.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// clear address counter walking one bank's address range
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "hist_defines.svh"

module clear_sweep (
    input  wire logic                             clk,
    input  wire logic                             arst_n,
    input  wire logic                             clear_start,
    output logic                                  busy,
    output logic [`HIST_UNIT_ADDR_WIDTH-1:0]      sweep_addr
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy       <= 1'b0;
            sweep_addr <= '0;
        end else if (busy) begin
            sweep_addr <= sweep_addr + 1'b1; // wraps back to zero after the last word
            if (sweep_addr == '1) begin
                busy <= 1'b0;
            end
        end else if (clear_start) begin
            busy       <= 1'b1;
            sweep_addr <= '0;
        end
    end

    // a sweep ends 64 busy cycles after the clear_start that began it
    a_busy_from_start: assert property (
        @(posedge clk) disable iff (!arst_n)
        $fell(busy) |-> $past(clear_start, 65)
    );

endmodule

`default_nettype wire

//--- hist_ram/hist_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// banked histogram RAM with a self-clearing sweep and a
// registered bank select on the read data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "hist_defines.svh"

module hist_ram
    import hist_ram_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    arst_n,
    input  wire ram_rd_t rd,
    output count_t       rd_data,
    input  wire ram_wr_t wr,
    input  wire logic    clear_start,
    output logic         clear_busy
);

    localparam int BIN_W  = `HIST_BIN_WIDTH;
    localparam int UNIT_W = `HIST_UNIT_ADDR_WIDTH;
    localparam int SEL_W  = BIN_W - UNIT_W;
    localparam int N      = 1 << SEL_W;

    logic [UNIT_W-1:0]  sweep_addr;
    logic [SEL_W-1:0]   wr_sel;
    logic [SEL_W-1:0]   rd_sel;
    logic [SEL_W-1:0]   rd_sel_q;
    ram_rd_t            unit_rd;
    ram_wr_t [N-1:0]    unit_wr;
    count_t  [N-1:0]    unit_data;

    clear_sweep i_clear_sweep (
        .clk         (clk),
        .arst_n      (arst_n),
        .clear_start (clear_start),
        .busy        (clear_busy),
        .sweep_addr  (sweep_addr)
    );

    assign wr_sel = wr.addr[BIN_W-1:UNIT_W];
    assign rd_sel = rd.addr[BIN_W-1:UNIT_W];

    // every bank sees the read, the registered select picks one
    assign unit_rd.en   = rd.en;
    assign unit_rd.addr = {{SEL_W{1'b0}}, rd.addr[UNIT_W-1:0]};

    always_comb begin
        for (int i = 0; i < N; i++) begin
            if (clear_busy) begin // clear overrides any pending write
                unit_wr[i].we   = 1'b1;
                unit_wr[i].addr = {{SEL_W{1'b0}}, sweep_addr};
                unit_wr[i].data = '0;
            end else begin
                unit_wr[i].we   = wr.we && (wr_sel == SEL_W'(i));
                unit_wr[i].addr = {{SEL_W{1'b0}}, wr.addr[UNIT_W-1:0]};
                unit_wr[i].data = wr.data;
            end
        end
    end

    for (genvar i = 0; i < N; i++) begin : g_bank
        ram_bank i_ram_bank (
            .clk     (clk),
            .rd      (unit_rd),
            .rd_data (unit_data[i]),
            .wr      (unit_wr[i])
        );
    end

    always_ff @(posedge clk) begin
        if (rd.en) begin
            rd_sel_q <= rd_sel; // lines up with the bank's registered data
        end
    end

    assign rd_data = unit_data[rd_sel_q];

    a_no_read_in_clear: assert property (
        @(posedge clk) disable iff (!arst_n)
        clear_busy |-> !rd.en
    );

endmodule

`default_nettype wire

//--- hist_ram/ram_bank.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one bank of the histogram RAM, read on port 0 and written
// on port 1, with a one-cycle registered read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "hist_defines.svh"

module ram_bank
    import hist_ram_pkg::*;
(
    input  wire logic    clk,
    input  wire ram_rd_t rd,
    output count_t       rd_data,
    input  wire ram_wr_t wr
);

    localparam int UNIT_W     = `HIST_UNIT_ADDR_WIDTH;
    localparam int UNIT_WORDS = 1 << UNIT_W;

    count_t mem [0:UNIT_WORDS-1];

    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr.addr[UNIT_W-1:0]] <= wr.data;
        end
    end

    // a read of the word being written returns the old value
    always_ff @(posedge clk) begin
        if (rd.en) begin
            rd_data <= mem[rd.addr[UNIT_W-1:0]];
        end
    end

endmodule

`default_nettype wire

//--- hist_top.f
+incdir+common
common/hist_ram_pkg.sv
common/hist_ctrl_pkg.sv
hist_ram/ram_bank.sv
hist_ram/clear_sweep.sv
hist_ram/hist_ram.sv
source/hist_fsm.sv
source/hist_accum.sv
source/hist_top.sv
tests/tb_clock_gen.sv
tests/tb_hist_top.sv

//--- run_sim.sh
#!/bin/sh
# builds the histogram testbench with Verilator and runs it into sim.log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_hist_top -f hist_top.f -o sim_hist

# tee keeps the pipeline status at zero so the log is always searched
./obj_dir/sim_hist | tee sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
if ! grep -q "all tests passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation PASSED"

//--- source/hist_accum.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// read-modify-write increment pipeline with forwarding
// and saturating counts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "hist_defines.svh"

module hist_accum
    import hist_ram_pkg::*, hist_ctrl_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   arst_n,
    input  wire pixel_t pixel,
    input  wire logic   collect_en,
    output ram_rd_t     rd,
    input  wire count_t rd_data,
    output ram_wr_t     wr
);

    logic                       s1_valid;
    logic [`HIST_BIN_WIDTH-1:0] s1_bin;
    ram_wr_t                    wr_q;   // write that lands on the RAM this cycle
    count_t                     base;
    count_t                     next;

    // the read goes out in the same cycle the pixel is accepted
    assign rd.en   = pixel.valid && collect_en;
    assign rd.addr = pixel.bin;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= pixel.valid && collect_en;
        end
    end

    always_ff @(posedge clk) begin
        s1_bin <= pixel.bin;
    end

    // newest write wins, the RAM data is stale for both
    always_comb begin
        if (wr.we && wr.addr == s1_bin) begin
            base = wr.data;
        end else if (wr_q.we && wr_q.addr == s1_bin) begin
            base = wr_q.data;
        end else begin
            base = rd_data;
        end
        next = (base == '1) ? base : base + 1'b1; // hold at the maximum count
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr.we   <= 1'b0;
            wr_q.we <= 1'b0;
        end else begin
            wr.we     <= s1_valid;
            wr.addr   <= s1_bin;
            wr.data   <= next;
            wr_q      <= wr;
        end
    end

    a_no_write_after_collect: assert property (
        @(posedge clk) disable iff (!arst_n)
        !collect_en && $past(!collect_en) && $past(!collect_en, 2) |-> !wr.we
    );

endmodule

`default_nettype wire

//--- source/hist_fsm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame controller: clear, collect, drain and readout phases
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module hist_fsm
    import hist_ctrl_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   arst_n,
    input  wire logic   start,
    input  wire logic   frame_end,
    input  wire logic   clear_busy,
    output logic        clear_start,
    output logic        collect_en,
    output hist_status_t status
);

    localparam int DRAIN_LEN = 2; // depth of the accumulator pipeline

    hist_state_e state;
    hist_state_e state_next;
    logic [1:0]  drain_cnt;

    always_comb begin
        state_next = state;
        case (state)
            st_idle:    if (start)                      state_next = st_clear;
            st_clear:   if (!clear_busy)                state_next = st_collect;
            st_collect: if (frame_end)                  state_next = st_drain;
            st_drain:   if (drain_cnt == DRAIN_LEN - 1) state_next = st_done;
            st_done:    if (start)                      state_next = st_clear;
            default:                                    state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_idle;
            drain_cnt <= '0;
        end else begin
            state <= state_next;
            if (state == st_drain) begin
                drain_cnt <= drain_cnt + 1'b1;
            end else begin
                drain_cnt <= '0;
            end
        end
    end

    // the sweep raises busy on the same edge that enters clear
    assign clear_start = start && (state == st_idle || state == st_done);
    assign collect_en  = (state == st_collect);

    assign status.state = state;
    assign status.ready = (state == st_done);

    a_collect_not_in_clear: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(collect_en && clear_busy)
    );

endmodule

`default_nettype wire

//--- source/hist_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// histogram engine top: controller, accumulator and RAM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module hist_top
    import hist_ram_pkg::*, hist_ctrl_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    arst_n,
    input  wire logic    start,
    input  wire logic    frame_end,
    input  wire pixel_t  pixel,
    input  wire ram_rd_t host_rd,
    output count_t       rd_data,
    output hist_status_t status
);

    logic    clear_start;
    logic    clear_busy;
    logic    collect_en;
    ram_rd_t accum_rd;
    ram_rd_t ram_rd;
    ram_wr_t accum_wr;

    hist_fsm i_hist_fsm (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (start),
        .frame_end   (frame_end),
        .clear_busy  (clear_busy),
        .clear_start (clear_start),
        .collect_en  (collect_en),
        .status      (status)
    );

    hist_accum i_hist_accum (
        .clk        (clk),
        .arst_n     (arst_n),
        .pixel      (pixel),
        .collect_en (collect_en),
        .rd         (accum_rd),
        .rd_data    (rd_data),
        .wr         (accum_wr)
    );

    // the host owns the read port only once the frame is done
    assign ram_rd = (status.state == st_done) ? host_rd : accum_rd;

    hist_ram i_hist_ram (
        .clk         (clk),
        .arst_n      (arst_n),
        .rd          (ram_rd),
        .rd_data     (rd_data),
        .wr          (accum_wr),
        .clear_start (clear_start),
        .clear_busy  (clear_busy)
    );

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock (40 ns) and active low reset for 10 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1; // released away from the rising edge
    end

endmodule

`default_nettype wire

//--- tests/tb_hist_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// histogram engine testbench: frame table, reference counts,
// LCG pixel source and typed compare tasks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "hist_defines.svh"

module tb_hist_top
    import hist_ram_pkg::*, hist_ctrl_pkg::*;
();

    localparam int N_BINS    = 1 << `HIST_BIN_WIDTH;
    localparam int COUNT_MAX = (1 << `HIST_COUNT_WIDTH) - 1;
    localparam int N_ROWS    = 5;
    localparam int TIMEOUT   = 200;

    logic         clk;
    logic         arst_n;
    logic         start;
    logic         frame_end;
    pixel_t       pixel;
    ram_rd_t      host_rd;
    count_t       rd_data;
    hist_status_t status;
    logic [31:0]  seed;
    int           ref_cnt [N_BINS];

    // one frame per row, a zero mask gives back-to-back hits on bin 0
    string      row_name [N_ROWS] = '{"random_all", "repeat_one", "saturate",
                                      "four_banks", "after_dirty"};
    int         row_pixels [N_ROWS] = '{600, 40, 300, 200, 400};
    logic [7:0] row_mask [N_ROWS]   = '{8'hff, 8'h00, 8'h00, 8'hc3, 8'hff};
    bit         row_skip_clear [N_ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0};

    tb_clock_gen i_tb_clock_gen (.clk(clk), .arst_n(arst_n));

    hist_top i_hist_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .frame_end (frame_end),
        .pixel     (pixel),
        .host_rd   (host_rd),
        .rd_data   (rd_data),
        .status    (status)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic hist_status_t expect_status(input hist_state_e s, input logic ready);
        hist_status_t st;
        st.state = s;
        st.ready = ready;
        return st;
    endfunction

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_count(input string name, input count_t exp, input count_t act);
        if (act !== exp) begin
            $display("mismatch %s: expected %0d actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_status(input string name, input hist_status_t exp,
                                input hist_status_t act);
        if (act !== exp) begin
            $display("mismatch %s: expected state %0d ready %0b actual state %0d ready %0b",
                     name, exp.state, exp.ready, act.state, act.ready);
            abort_run();
        end
    endtask

    task automatic check_cycles(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("mismatch %s: expected %0d cycles actual %0d cycles", name, exp, act);
            abort_run();
        end
    endtask

    // pixels outside collect, the DUT has to drop them
    task automatic drive_junk();
        seed        = lcg_next(seed);
        pixel.valid = seed[4];
        pixel.bin   = seed[23:16];
    endtask

    task automatic wait_state(input hist_state_e target, input bit junk, output int cycles);
        bit reached;
        reached = 1'b0;
        cycles  = 0;
        for (int i = 0; i < TIMEOUT && !reached; i++) begin
            @(negedge clk);
            if (status.state == target) begin
                reached = 1'b1;
            end else begin
                cycles++;
                if (junk) begin
                    drive_junk();
                end
            end
        end
        pixel.valid = 1'b0;
        if (!reached) begin
            $display("timeout: state %0d was never reached, stuck in state %0d",
                     target, status.state);
            abort_run();
        end
    endtask

    task automatic start_frame();
        int n;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_status("enter clear", expect_status(st_clear, 1'b0), status);
        foreach (ref_cnt[i]) begin
            ref_cnt[i] = 0;
        end
        wait_state(st_collect, 1'b1, n);
        check_cycles("clear length", 65, n + 1); // 64 sweep writes, then busy seen low
    endtask

    task automatic end_frame();
        int n;
        @(negedge clk);
        pixel.valid = 1'b0;
        frame_end   = 1'b1;
        @(negedge clk);
        frame_end = 1'b0;
        check_status("enter drain", expect_status(st_drain, 1'b0), status);
        wait_state(st_done, 1'b0, n);
        check_cycles("drain length", 2, n + 1);
        check_status("enter done", expect_status(st_done, 1'b1), status);
    endtask

    task automatic send_pixels(input int row);
        int sent;
        sent = 0;
        while (sent < row_pixels[row]) begin
            @(negedge clk);
            seed = lcg_next(seed);
            if (seed[3:2] == 2'b00 && row_mask[row] != 8'h00) begin
                pixel.valid = 1'b0; // idle gaps vary the distance between repeats
            end else begin
                pixel.valid = 1'b1;
                pixel.bin   = seed[23:16] & row_mask[row];
                if (ref_cnt[pixel.bin] < COUNT_MAX) begin
                    ref_cnt[pixel.bin]++;
                end
                sent++;
            end
        end
    endtask

    // back-to-back reads, each word is checked one cycle after its enable
    task automatic read_all(input string name, input bit expect_zero);
        count_t exp;
        for (int a = 0; a <= N_BINS; a++) begin
            @(negedge clk);
            if (a > 0) begin
                exp = expect_zero ? count_t'(0) : count_t'(ref_cnt[a - 1]);
                check_count($sformatf("%s bin %0d", name, a - 1), exp, rd_data);
            end
            host_rd.en   = (a < N_BINS);
            host_rd.addr = a[`HIST_BIN_WIDTH-1:0];
            drive_junk();
        end
        host_rd.en  = 1'b0;
        pixel.valid = 1'b0;
    endtask

    initial begin
        int n;
        start     = 1'b0;
        frame_end = 1'b0;
        pixel     = '0;
        host_rd   = '0;
        seed      = 32'h98d1;
        n         = 0;
        while (arst_n !== 1'b1 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (arst_n !== 1'b1) begin
            $display("timeout: reset was never released");
            abort_run();
        end
        @(negedge clk);
        check_status("after reset", expect_status(st_idle, 1'b0), status);
        for (int r = 0; r < N_ROWS; r++) begin
            if (!row_skip_clear[r]) begin
                start_frame(); // empty frame shows the clear left every bin at zero
                end_frame();
                read_all({row_name[r], " cleared"}, 1'b1);
            end
            start_frame();
            send_pixels(r);
            end_frame();
            read_all(row_name[r], 1'b0);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire
